// File: hw/gpioBlock.sv
//----------------------------------------------------------------------------
// GPIO slave on the USI bus. Two CSRs drive the status LEDs and the RGB LED
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module gpioBlock (
	input  logic                   iSysClk,
	input  logic                   rstN,
	input  usiPkg::usiSlvReqT      req,
	output logic [`USI_DATA_W-1:0] rd,
	output logic [1:0]             led,
	output logic [2:0]             ledRgb
);

	logic [1:0]             ledQ;
	logic [2:0]             rgbQ;
	logic [`USI_DATA_W-1:0] readWord;

	// CSR writes
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ledQ <= '0;
			rgbQ <= '0;
		end
		else if (req.wEd)
		begin
			case (int'(req.csr))
				`GPIO_CSR_LED: ledQ <= req.wd[1:0];
				`GPIO_CSR_RGB: rgbQ <= req.wd[2:0];
				default:       ;
			endcase
		end
	end

	// Readback, unused indices read as zero
	always_comb
	begin
		case (int'(req.csr))
			`GPIO_CSR_LED: readWord = `USI_DATA_W'(ledQ);
			`GPIO_CSR_RGB: readWord = `USI_DATA_W'(rgbQ);
			default:       readWord = '0;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (req.rEd)
			rd <= readWord;
	end

	// Pins follow the CSRs directly
	assign led    = ledQ;
	assign ledRgb = rgbQ;

endmodule

`default_nettype wire

// File: hw/usiBus.sv
//----------------------------------------------------------------------------
// USI bus decoder. Routes each request to the slave named by the block
// field and returns one read response per read, zero for unmapped blocks.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module usiBus (
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Master side
	input  usiPkg::usiReqT         busReq,
	output usiPkg::usiRspT         busRsp,
	// GPIO slave
	output usiPkg::usiSlvReqT      gpioReq,
	input  logic [`USI_DATA_W-1:0] gpioRd,
	// Video timing slave
	output usiPkg::usiSlvReqT      vtbReq,
	input  logic [`USI_DATA_W-1:0] vtbRd
);

	import usiPkg::*;

	// Stage 1, request toward the slaves
	logic                   wEdQ;
	logic                   rEdQ;
	usiAdrsT                adrsQ;
	logic [`USI_DATA_W-1:0] wdQ;
	logic                   gpioSel;
	logic                   vtbSel;

	// Stage 2, read waiting for slave data
	logic                   rEdPendQ;
	logic [`USI_BLOCK_W-1:0] blkPendQ;
	logic [`USI_DATA_W-1:0] selRd;

	// Response
	logic                   rspValidQ;
	logic [`USI_DATA_W-1:0] rspDataQ;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wEdQ      <= 1'b0;
			rEdQ      <= 1'b0;
			rEdPendQ  <= 1'b0;
			rspValidQ <= 1'b0;
		end
		else
		begin
			wEdQ      <= busReq.wEd;
			rEdQ      <= busReq.rEd;
			rEdPendQ  <= rEdQ;
			rspValidQ <= rEdPendQ;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		adrsQ    <= busReq.adrs;
		wdQ      <= busReq.wd;
		blkPendQ <= adrsQ.fields.block;
		rspDataQ <= rEdPendQ ? selRd : '0;
	end

	//------------------------------------------------------------------------
	// Block decode, strobes reach one slave only
	//------------------------------------------------------------------------
	assign gpioSel = (int'(adrsQ.fields.block) == `GPIO_BLOCK_ID);
	assign vtbSel  = (int'(adrsQ.fields.block) == `VTB_BLOCK_ID);

	assign gpioReq = '{wEd: wEdQ & gpioSel, rEd: rEdQ & gpioSel,
		csr: adrsQ.fields.csr, wd: wdQ};
	assign vtbReq  = '{wEd: wEdQ & vtbSel, rEd: rEdQ & vtbSel,
		csr: adrsQ.fields.csr, wd: wdQ};

	// Read data select by the block recorded with the read
	always_comb
	begin
		case (int'(blkPendQ))
			`GPIO_BLOCK_ID: selRd = gpioRd;
			`VTB_BLOCK_ID:  selRd = vtbRd;
			default:        selRd = '0;
		endcase
	end

	assign busRsp = '{rEd: rspValidQ, rd: rspDataQ};

endmodule

`default_nettype wire

// File: hw/usiHostPort.sv
//----------------------------------------------------------------------------
// Host side of the USI bus. Registers host strobes into a bus request and
// registers the bus read response back to the host.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module usiHostPort (
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Host
	input  logic                   hostWEd,
	input  logic                   hostREd,
	input  logic [`USI_ADRS_W-1:0] hostAdrs,
	input  logic [`USI_DATA_W-1:0] hostWd,
	output usiPkg::usiRspT         hostRsp,
	// Bus
	output usiPkg::usiReqT         busReq,
	input  usiPkg::usiRspT         busRsp
);

	import usiPkg::*;

	// Request stage
	logic                   wEdQ;
	logic                   rEdQ;
	usiAdrsT                adrsQ;
	logic [`USI_DATA_W-1:0] wdQ;

	// Response stage
	logic                   rspValidQ;
	logic [`USI_DATA_W-1:0] rspDataQ;

	//------------------------------------------------------------------------
	// Host to bus
	//------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wEdQ <= 1'b0;
			rEdQ <= 1'b0;
		end
		else
		begin
			wEdQ <= hostWEd;
			rEdQ <= hostREd;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		adrsQ.raw <= hostAdrs;
		wdQ       <= hostWd;
	end

	assign busReq = '{wEd: wEdQ, rEd: rEdQ, adrs: adrsQ, wd: wdQ};

	//------------------------------------------------------------------------
	// Bus to host
	//------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rspValidQ <= 1'b0;
		else
			rspValidQ <= busRsp.rEd;
	end

	always_ff @(posedge iSysClk)
	begin
		rspDataQ <= busRsp.rd;
	end

	assign hostRsp = '{rEd: rspValidQ, rd: rspDataQ};

endmodule

`default_nettype wire

// File: hw/usiPkg.sv
//----------------------------------------------------------------------------
// Request, response and address types shared by the USI register bus,
// its host port and the slave blocks
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

package usiPkg;

	//------------------------------------------------------------------------
	// Address word
	//------------------------------------------------------------------------
	// Field view of the bus address
	typedef struct packed {
		logic [`USI_ADRS_W-`USI_BLOCK_W-`USI_CSR_W-1:0] unused;
		logic [`USI_BLOCK_W-1:0]                         block;
		logic [`USI_CSR_W-1:0]                           csr;
	} usiAdrsFieldsT;

	// Host writes raw, bus decodes fields
	typedef union packed {
		logic [`USI_ADRS_W-1:0] raw;
		usiAdrsFieldsT          fields;
	} usiAdrsT;

	//------------------------------------------------------------------------
	// Requests and responses
	//------------------------------------------------------------------------
	// Master side request, one strobe at most
	typedef struct packed {
		logic                   wEd;
		logic                   rEd;
		usiAdrsT                adrs;
		logic [`USI_DATA_W-1:0] wd;
	} usiReqT;

	// Request after block decode, as one slave sees it
	typedef struct packed {
		logic                   wEd;
		logic                   rEd;
		logic [`USI_CSR_W-1:0]  csr;
		logic [`USI_DATA_W-1:0] wd;
	} usiSlvReqT;

	// Read return, rEd pulses once per read
	typedef struct packed {
		logic                   rEd;
		logic [`USI_DATA_W-1:0] rd;
	} usiRspT;

endpackage

`default_nettype wire

// File: hw/usiSystem.sv
//----------------------------------------------------------------------------
// Top level of the register system. Host port, USI bus decoder, GPIO block
// and video timing block on the system clock.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module usiSystem (
	input  logic                   iSysClk,
	input  logic                   rstN,
	// Host
	input  logic                   hostWEd,
	input  logic                   hostREd,
	input  logic [`USI_ADRS_W-1:0] hostAdrs,
	input  logic [`USI_DATA_W-1:0] hostWd,
	output usiPkg::usiRspT         hostRsp,
	// LEDs
	output logic [1:0]             led,
	output logic [2:0]             ledRgb,
	// Display timing
	output logic                   hSync,
	output logic                   vSync,
	output logic                   de
);

	import usiPkg::*;

	usiReqT                 busReq;
	usiRspT                 busRsp;
	usiSlvReqT              gpioReq;
	usiSlvReqT              vtbReq;
	logic [`USI_DATA_W-1:0] gpioRd;
	logic [`USI_DATA_W-1:0] vtbRd;

	usiHostPort hostPort (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.hostWEd (hostWEd),
		.hostREd (hostREd),
		.hostAdrs(hostAdrs),
		.hostWd  (hostWd),
		.hostRsp (hostRsp),
		.busReq  (busReq),
		.busRsp  (busRsp)
	);

	usiBus bus (
		.iSysClk(iSysClk),
		.rstN   (rstN),
		.busReq (busReq),
		.busRsp (busRsp),
		.gpioReq(gpioReq),
		.gpioRd (gpioRd),
		.vtbReq (vtbReq),
		.vtbRd  (vtbRd)
	);

	gpioBlock gpio (
		.iSysClk(iSysClk),
		.rstN   (rstN),
		.req    (gpioReq),
		.rd     (gpioRd),
		.led    (led),
		.ledRgb (ledRgb)
	);

	videoTimingBlock vtb (
		.iSysClk(iSysClk),
		.rstN   (rstN),
		.req    (vtbReq),
		.rd     (vtbRd),
		.hSync  (hSync),
		.vSync  (vSync),
		.de     (de)
	);

endmodule

`default_nettype wire

// File: hw/usiSystem_params.svh
//----------------------------------------------------------------------------
// Bus widths, block map, CSR indices and display timing defaults for the
// USI register system. Included by the package, the RTL and the testbench.
//----------------------------------------------------------------------------
`ifndef USI_SYSTEM_PARAMS_SVH
`define USI_SYSTEM_PARAMS_SVH

// USI bus geometry
`define USI_DATA_W        32
`define USI_ADRS_W        32
`define USI_BLOCK_W       4
`define USI_CSR_W         16

// Block address map
`define GPIO_BLOCK_ID     1
`define VTB_BLOCK_ID      4

// GPIO CSRs
`define GPIO_CSR_LED      0
`define GPIO_CSR_RGB      1

// Video timing CSRs
`define VTB_CSR_ENABLE    0
`define VTB_CSR_HDISPLAY  1
`define VTB_CSR_HFRONT    2
`define VTB_CSR_HPULSE    3
`define VTB_CSR_HBACK     4
`define VTB_CSR_VDISPLAY  5
`define VTB_CSR_VFRONT    6
`define VTB_CSR_VPULSE    7
`define VTB_CSR_VBACK     8

// Timing field widths, porch width shared by front, pulse and back
`define H_DISPLAY_W       11
`define H_PORCH_W         7
`define V_DISPLAY_W       11
`define V_PORCH_W         5

// 480x272 panel defaults
`define H_DISPLAY_RST     480
`define H_FRONT_RST       8
`define H_PULSE_RST       30
`define H_BACK_RST        43
`define V_DISPLAY_RST     272
`define V_FRONT_RST       12
`define V_PULSE_RST       10
`define V_BACK_RST        4

`endif

// File: hw/videoTimingBlock.sv
//----------------------------------------------------------------------------
// Video timing slave. Holds display and porch CSRs and generates active low
// hSync and vSync plus de, one pixel per system clock.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module videoTimingBlock (
	input  logic                   iSysClk,
	input  logic                   rstN,
	input  usiPkg::usiSlvReqT      req,
	output logic [`USI_DATA_W-1:0] rd,
	output logic                   hSync,
	output logic                   vSync,
	output logic                   de
);

	// One extra bit covers display plus all three porches
	localparam int hCntW = `H_DISPLAY_W + 1;
	localparam int vCntW = `V_DISPLAY_W + 1;

	// CSRs
	logic                    vtbEnable;
	logic [`H_DISPLAY_W-1:0] hDisplay;
	logic [`H_PORCH_W-1:0]   hFront;
	logic [`H_PORCH_W-1:0]   hPulse;
	logic [`H_PORCH_W-1:0]   hBack;
	logic [`V_DISPLAY_W-1:0] vDisplay;
	logic [`V_PORCH_W-1:0]   vFront;
	logic [`V_PORCH_W-1:0]   vPulse;
	logic [`V_PORCH_W-1:0]   vBack;
	logic [`USI_DATA_W-1:0]  readWord;

	// Counters and their limits
	logic [hCntW-1:0] hCnt;
	logic [vCntW-1:0] vCnt;
	logic [hCntW-1:0] hSyncStart;
	logic [hCntW-1:0] hSyncEnd;
	logic [hCntW-1:0] hTotal;
	logic [vCntW-1:0] vSyncStart;
	logic [vCntW-1:0] vSyncEnd;
	logic [vCntW-1:0] vTotal;

	//------------------------------------------------------------------------
	// CSR access
	//------------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			vtbEnable <= 1'b0;
			hDisplay  <= `H_DISPLAY_W'(`H_DISPLAY_RST);
			hFront    <= `H_PORCH_W'(`H_FRONT_RST);
			hPulse    <= `H_PORCH_W'(`H_PULSE_RST);
			hBack     <= `H_PORCH_W'(`H_BACK_RST);
			vDisplay  <= `V_DISPLAY_W'(`V_DISPLAY_RST);
			vFront    <= `V_PORCH_W'(`V_FRONT_RST);
			vPulse    <= `V_PORCH_W'(`V_PULSE_RST);
			vBack     <= `V_PORCH_W'(`V_BACK_RST);
		end
		else if (req.wEd)
		begin
			// Values truncate to the field width
			case (int'(req.csr))
				`VTB_CSR_ENABLE:   vtbEnable <= req.wd[0];
				`VTB_CSR_HDISPLAY: hDisplay  <= req.wd[`H_DISPLAY_W-1:0];
				`VTB_CSR_HFRONT:   hFront    <= req.wd[`H_PORCH_W-1:0];
				`VTB_CSR_HPULSE:   hPulse    <= req.wd[`H_PORCH_W-1:0];
				`VTB_CSR_HBACK:    hBack     <= req.wd[`H_PORCH_W-1:0];
				`VTB_CSR_VDISPLAY: vDisplay  <= req.wd[`V_DISPLAY_W-1:0];
				`VTB_CSR_VFRONT:   vFront    <= req.wd[`V_PORCH_W-1:0];
				`VTB_CSR_VPULSE:   vPulse    <= req.wd[`V_PORCH_W-1:0];
				`VTB_CSR_VBACK:    vBack     <= req.wd[`V_PORCH_W-1:0];
				default:           ;
			endcase
		end
	end

	always_comb
	begin
		case (int'(req.csr))
			`VTB_CSR_ENABLE:   readWord = `USI_DATA_W'(vtbEnable);
			`VTB_CSR_HDISPLAY: readWord = `USI_DATA_W'(hDisplay);
			`VTB_CSR_HFRONT:   readWord = `USI_DATA_W'(hFront);
			`VTB_CSR_HPULSE:   readWord = `USI_DATA_W'(hPulse);
			`VTB_CSR_HBACK:    readWord = `USI_DATA_W'(hBack);
			`VTB_CSR_VDISPLAY: readWord = `USI_DATA_W'(vDisplay);
			`VTB_CSR_VFRONT:   readWord = `USI_DATA_W'(vFront);
			`VTB_CSR_VPULSE:   readWord = `USI_DATA_W'(vPulse);
			`VTB_CSR_VBACK:    readWord = `USI_DATA_W'(vBack);
			default:           readWord = '0;
		endcase
	end

	always_ff @(posedge iSysClk)
	begin
		if (req.rEd)
			rd <= readWord;
	end

	//------------------------------------------------------------------------
	// Timing generator
	//------------------------------------------------------------------------
	// Sync windows sit after the front porch
	assign hSyncStart = hCntW'(hDisplay) + hCntW'(hFront);
	assign hSyncEnd   = hSyncStart + hCntW'(hPulse);
	assign hTotal     = hSyncEnd + hCntW'(hBack);
	assign vSyncStart = vCntW'(vDisplay) + vCntW'(vFront);
	assign vSyncEnd   = vSyncStart + vCntW'(vPulse);
	assign vTotal     = vSyncEnd + vCntW'(vBack);

	// Held at zero while disabled, so a new enable starts a clean frame
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (!vtbEnable)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hCnt >= hTotal - 1'b1)
		begin
			hCnt <= '0;
			if (vCnt >= vTotal - 1'b1)
				vCnt <= '0;
			else
				vCnt <= vCnt + 1'b1;
		end
		else
		begin
			hCnt <= hCnt + 1'b1;
		end
	end

	// Registered pins, idle levels while disabled
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			de    <= 1'b0;
		end
		else
		begin
			hSync <= !(vtbEnable && hCnt >= hSyncStart && hCnt < hSyncEnd);
			vSync <= !(vtbEnable && vCnt >= vSyncStart && vCnt < vSyncEnd);
			de    <= vtbEnable && hCnt < hCntW'(hDisplay) && vCnt < vCntW'(vDisplay);
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the USI system testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module usiSystem_tb -f usiSystem.f -o simv

# The log decides the result, so a nonzero simulator exit is not fatal here
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "run.sh: failure reported in sim.log"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "run.sh: simulation ended without a result line"
	exit 1
fi
echo "run.sh: done"

// File: tests/usiSystem_props.sv
//----------------------------------------------------------------------------
// Concurrent assertions for the USI system, bound into the top level.
// Covers reset state, read latency, LED writes and video timing.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module usiSystemProps (
	input logic                   iSysClk,
	input logic                   rstN,
	input logic                   hostWEd,
	input logic                   hostREd,
	input logic [`USI_ADRS_W-1:0] hostAdrs,
	input logic [`USI_DATA_W-1:0] hostWd,
	input usiPkg::usiRspT         hostRsp,
	input logic [1:0]             led,
	input logic [2:0]             ledRgb,
	input logic                   hSync,
	input logic                   vSync,
	input logic                   de
);

	int                      failCount = 0;
	logic [`USI_BLOCK_W-1:0] hostBlk;
	int                      hostCsr;
	logic                    ledWr;
	logic                    rgbWr;
	logic                    vtbWr;

	// Timing seen from host writes
	logic enM;
	int   hDispM;
	int   hFrontM;
	int   hPulseM;
	int   hBackM;
	int   hTotalM;

	// hSync measurement
	int   lowCnt;
	int   perCnt;
	logic lineSeen;
	logic hSyncQ;

	assign hostBlk = hostAdrs[`USI_CSR_W +: `USI_BLOCK_W];
	assign hostCsr = int'(hostAdrs[`USI_CSR_W-1:0]);
	assign ledWr   = hostWEd && int'(hostBlk) == `GPIO_BLOCK_ID && hostCsr == `GPIO_CSR_LED;
	assign rgbWr   = hostWEd && int'(hostBlk) == `GPIO_BLOCK_ID && hostCsr == `GPIO_CSR_RGB;
	assign vtbWr   = hostWEd && int'(hostBlk) == `VTB_BLOCK_ID;
	assign hTotalM = hDispM + hFrontM + hPulseM + hBackM;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enM     <= 1'b0;
			hDispM  <= `H_DISPLAY_RST;
			hFrontM <= `H_FRONT_RST;
			hPulseM <= `H_PULSE_RST;
			hBackM  <= `H_BACK_RST;
		end
		else if (vtbWr)
		begin
			case (hostCsr)
				`VTB_CSR_ENABLE:   enM     <= hostWd[0];
				`VTB_CSR_HDISPLAY: hDispM  <= int'(hostWd[`H_DISPLAY_W-1:0]);
				`VTB_CSR_HFRONT:   hFrontM <= int'(hostWd[`H_PORCH_W-1:0]);
				`VTB_CSR_HPULSE:   hPulseM <= int'(hostWd[`H_PORCH_W-1:0]);
				`VTB_CSR_HBACK:    hBackM  <= int'(hostWd[`H_PORCH_W-1:0]);
				default:           ;
			endcase
		end
	end

	// Low cycles of the current hSync pulse, and cycles since its last fall
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			lowCnt   <= 0;
			perCnt   <= 0;
			lineSeen <= 1'b0;
			hSyncQ   <= 1'b1;
		end
		else
		begin
			hSyncQ <= hSync;
			lowCnt <= hSync ? 0 : lowCnt + 1;
			if (!enM)
			begin
				perCnt   <= 0;
				lineSeen <= 1'b0;
			end
			else if (hSyncQ && !hSync)
			begin
				perCnt   <= 1;
				lineSeen <= 1'b1;
			end
			else
			begin
				perCnt <= perCnt + 1;
			end
		end
	end

	//------------------------------------------------------------------------
	// Assertions
	//------------------------------------------------------------------------
	resetStateA: assert property (@(posedge iSysClk) $rose(rstN) |->
		(!hostRsp.rEd && led == '0 && ledRgb == '0 && !de && hSync && vSync))
		else begin failCount++; $error("outputs not at reset state"); end

	// Response flop loads at the fourth edge, so it is sampled at the fifth
	readRspA: assert property (@(posedge iSysClk) disable iff (!rstN)
		hostREd |-> ##5 hostRsp.rEd)
		else begin failCount++; $error("read got no response 4 cycles later"); end

	rspHasReadA: assert property (@(posedge iSysClk) disable iff (!rstN)
		hostRsp.rEd |-> $past(hostREd, 5))
		else begin failCount++; $error("response without a read 4 cycles before"); end

	ledWriteA: assert property (@(posedge iSysClk) disable iff (!rstN)
		ledWr |-> ##3 led == $past(hostWd[1:0], 3))
		else begin failCount++; $error("led pins do not follow the write"); end

	rgbWriteA: assert property (@(posedge iSysClk) disable iff (!rstN)
		rgbWr |-> ##3 ledRgb == $past(hostWd[2:0], 3))
		else begin failCount++; $error("RGB pins do not follow the write"); end

	hPulseA: assert property (@(posedge iSysClk) disable iff (!rstN)
		$rose(hSync) && enM |-> lowCnt == hPulseM)
		else begin failCount++; $error("hSync pulse width differs from hpulse"); end

	hPeriodA: assert property (@(posedge iSysClk) disable iff (!rstN)
		$fell(hSync) && enM && lineSeen |-> perCnt == hTotalM)
		else begin failCount++; $error("hSync period differs from line length"); end

	deBlankA: assert property (@(posedge iSysClk) disable iff (!rstN)
		!(de && (!hSync || !vSync)))
		else begin failCount++; $error("de high during a sync pulse"); end

endmodule

bind usiSystem usiSystemProps props (
	.iSysClk (iSysClk),
	.rstN    (rstN),
	.hostWEd (hostWEd),
	.hostREd (hostREd),
	.hostAdrs(hostAdrs),
	.hostWd  (hostWd),
	.hostRsp (hostRsp),
	.led     (led),
	.ledRgb  (ledRgb),
	.hSync   (hSync),
	.vSync   (vSync),
	.de      (de)
);

`default_nettype wire

// File: tests/usiSystem_tb.sv
//----------------------------------------------------------------------------
// Testbench for the USI register system. Drives host reads and writes,
// checks read data against a CSR model and runs a small video frame.
//----------------------------------------------------------------------------
`default_nettype none

`include "usiSystem_params.svh"

module usiSystem_tb;

	import usiPkg::*;

	// Small display timing
	localparam int hDispS        = 10;
	localparam int hFrontS       = 2;
	localparam int hPulseS       = 3;
	localparam int hBackS        = 4;
	localparam int vDispS        = 4;
	localparam int vFrontS       = 1;
	localparam int vPulseS       = 2;
	localparam int vBackS        = 1;
	localparam int lineCycles    = hDispS + hFrontS + hPulseS + hBackS;
	localparam int frameCycles   = lineCycles * (vDispS + vFrontS + vPulseS + vBackS);
	localparam int stimCycles    = 220;
	localparam int timeoutCycles = (stimCycles + 2 * frameCycles) * 2;

	logic                   iSysClk;
	logic                   rstN;
	logic                   hostWEd;
	logic                   hostREd;
	logic [`USI_ADRS_W-1:0] hostAdrs;
	logic [`USI_DATA_W-1:0] hostWd;
	usiRspT                 hostRsp;
	logic [1:0]             led;
	logic [2:0]             ledRgb;
	logic                   hSync;
	logic                   vSync;
	logic                   de;

	// CSR model and expected reads in issue order
	logic [31:0] gpioModel [2];
	logic [31:0] vtbModel [9];
	logic [31:0] expQ [$];
	logic [31:0] expRd;
	integer      seed;
	int          readErrors = 0;
	int          pinErrors = 0;
	int          assertErrors;

	usiSystem dut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.hostWEd (hostWEd),
		.hostREd (hostREd),
		.hostAdrs(hostAdrs),
		.hostWd  (hostWd),
		.hostRsp (hostRsp),
		.led     (led),
		.ledRgb  (ledRgb),
		.hSync   (hSync),
		.vSync   (vSync),
		.de      (de)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;
	end

	function automatic logic [31:0] csrAdrs(input int blk, input int csr);
		return {{(`USI_ADRS_W - `USI_BLOCK_W - `USI_CSR_W){1'b0}},
			`USI_BLOCK_W'(blk), `USI_CSR_W'(csr)};
	endfunction

	// Stored bits of each video CSR
	function automatic int fieldWidth(input int csr);
		case (csr)
			`VTB_CSR_ENABLE:   return 1;
			`VTB_CSR_HDISPLAY: return `H_DISPLAY_W;
			`VTB_CSR_VDISPLAY: return `V_DISPLAY_W;
			`VTB_CSR_HFRONT, `VTB_CSR_HPULSE, `VTB_CSR_HBACK: return `H_PORCH_W;
			default:           return `V_PORCH_W;
		endcase
	endfunction

	function automatic logic [31:0] expectedRead(input logic [31:0] adrs);
		int blk;
		int csr;
		blk = int'(adrs[`USI_CSR_W +: `USI_BLOCK_W]);
		csr = int'(adrs[`USI_CSR_W-1:0]);
		if (blk == `GPIO_BLOCK_ID && csr < 2)
			return gpioModel[csr];
		if (blk == `VTB_BLOCK_ID && csr < 9)
			return vtbModel[csr];
		return '0;
	endfunction

	function automatic void modelWrite(input logic [31:0] adrs, input logic [31:0] wd);
		int blk;
		int csr;
		blk = int'(adrs[`USI_CSR_W +: `USI_BLOCK_W]);
		csr = int'(adrs[`USI_CSR_W-1:0]);
		if (blk == `GPIO_BLOCK_ID && csr == `GPIO_CSR_LED)
			gpioModel[csr] = wd & 32'h3;
		else if (blk == `GPIO_BLOCK_ID && csr == `GPIO_CSR_RGB)
			gpioModel[csr] = wd & 32'h7;
		else if (blk == `VTB_BLOCK_ID && csr < 9)
			vtbModel[csr] = wd & ((32'h1 << fieldWidth(csr)) - 32'h1);
	endfunction

	task automatic driveWrite(input logic [31:0] adrs, input logic [31:0] wd);
		@(negedge iSysClk);
		hostWEd  = 1'b1;
		hostREd  = 1'b0;
		hostAdrs = adrs;
		hostWd   = wd;
		modelWrite(adrs, wd);
	endtask

	task automatic driveRead(input logic [31:0] adrs);
		@(negedge iSysClk);
		hostWEd  = 1'b0;
		hostREd  = 1'b1;
		hostAdrs = adrs;
		hostWd   = '0;
		expQ.push_back(expectedRead(adrs));
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge iSysClk);
			hostWEd = 1'b0;
			hostREd = 1'b0;
		end
	endtask

	// Read data check, outputs are settled at the falling edge
	always @(negedge iSysClk)
	begin
		if (rstN && hostRsp.rEd)
		begin
			if (expQ.size() == 0)
			begin
				readErrors++;
				$display("Read response at %0t with no read outstanding", $time);
			end
			else
			begin
				expRd = expQ.pop_front();
				assert (hostRsp.rd == expRd)
				else
				begin
					readErrors++;
					$display("CHECK FAILED at %0t: read data %h, expected %h",
						$time, hostRsp.rd, expRd);
				end
			end
		end
	end

	initial
	begin
		logic [31:0] raw;
		logic [15:0] csrSel;
		seed     = 32'he5b8_45b6;
		rstN     = 1'b0;
		hostWEd  = 1'b0;
		hostREd  = 1'b0;
		hostAdrs = '0;
		hostWd   = '0;
		gpioModel[`GPIO_CSR_LED]  = '0;
		gpioModel[`GPIO_CSR_RGB]  = '0;
		vtbModel[`VTB_CSR_ENABLE]   = '0;
		vtbModel[`VTB_CSR_HDISPLAY] = `H_DISPLAY_RST;
		vtbModel[`VTB_CSR_HFRONT]   = `H_FRONT_RST;
		vtbModel[`VTB_CSR_HPULSE]   = `H_PULSE_RST;
		vtbModel[`VTB_CSR_HBACK]    = `H_BACK_RST;
		vtbModel[`VTB_CSR_VDISPLAY] = `V_DISPLAY_RST;
		vtbModel[`VTB_CSR_VFRONT]   = `V_FRONT_RST;
		vtbModel[`VTB_CSR_VPULSE]   = `V_PULSE_RST;
		vtbModel[`VTB_CSR_VBACK]    = `V_BACK_RST;
		repeat (2) @(negedge iSysClk);
		rstN = 1'b1;

		// Reset values, back to back
		for (int i = 0; i < 2; i++)
			driveRead(csrAdrs(`GPIO_BLOCK_ID, i));
		for (int i = 0; i < 9; i++)
			driveRead(csrAdrs(`VTB_BLOCK_ID, i));

		// LED writes and readback, plus an unused GPIO index
		driveWrite(csrAdrs(`GPIO_BLOCK_ID, `GPIO_CSR_LED), $random(seed));
		driveWrite(csrAdrs(`GPIO_BLOCK_ID, `GPIO_CSR_RGB), $random(seed));
		driveWrite(csrAdrs(`GPIO_BLOCK_ID, 5), $random(seed));
		driveRead(csrAdrs(`GPIO_BLOCK_ID, `GPIO_CSR_LED));
		driveRead(csrAdrs(`GPIO_BLOCK_ID, `GPIO_CSR_RGB));
		driveRead(csrAdrs(`GPIO_BLOCK_ID, 5));
		idleCycles(3);

		// Random reads, mostly low CSR indices
		for (int i = 0; i < 64; i++)
		begin
			raw    = $random(seed);
			csrSel = raw[4] ? raw[15:0] : {12'h0, raw[3:0]};
			driveRead({raw[31:16], csrSel});
		end

		// Wide values truncate to the field width
		for (int i = 1; i < 9; i++)
			driveWrite(csrAdrs(`VTB_BLOCK_ID, i), $random(seed));
		for (int i = 0; i < 9; i++)
			driveRead(csrAdrs(`VTB_BLOCK_ID, i));

		// Small frame, then enable
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_HDISPLAY), hDispS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_HFRONT), hFrontS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_HPULSE), hPulseS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_HBACK), hBackS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_VDISPLAY), vDispS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_VFRONT), vFrontS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_VPULSE), vPulseS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_VBACK), vBackS);
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_ENABLE), 32'h1);
		driveRead(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_ENABLE));
		idleCycles(2);
		repeat (3) @(negedge vSync);

		// Disable, pins return to idle levels
		driveWrite(csrAdrs(`VTB_BLOCK_ID, `VTB_CSR_ENABLE), 32'h0);
		idleCycles(6);
		assert (hSync && vSync && !de)
		else
		begin
			pinErrors++;
			$display("CHECK FAILED at %0t: sync or de not idle after disable", $time);
		end
		idleCycles(8);
		if (expQ.size() != 0)
		begin
			pinErrors++;
			$display("%0d reads never got a response", expQ.size());
		end

		assertErrors = dut.props.failCount;
		$display("Errors: read checks %0d, pin checks %0d, assertions %0d",
			readErrors, pinErrors, assertErrors);
		if (readErrors + pinErrors + assertErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (timeoutCycles) @(posedge iSysClk);
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: usiSystem.f
+incdir+hw
hw/usiPkg.sv
hw/usiHostPort.sv
hw/usiBus.sv
hw/gpioBlock.sv
hw/videoTimingBlock.sv
hw/usiSystem.sv
tests/usiSystem_props.sv
tests/usiSystem_tb.sv
